/* hdl/hostIfPkg.sv */
// Shared widths and types for the host read channel and the line fetchers
// Imported by every RTL module and by the host memory model
package hostIfPkg;

    // --------------------
    // Field widths
    // --------------------
    localparam int LINE_ADDR_W  = 32;             // Host line address
    localparam int REQ_TAG_W    = 8;              // Full request tag
    localparam int LINE_DATA_W  = 64;             // One line of data
    localparam int LINE_COUNT_W = 16;             // Lines per fetch

    // Tag layout
    // Top bit names the client, set by the arbiter
    localparam int CLIENT_BIT = REQ_TAG_W - 1;
    localparam int SEQ_W      = REQ_TAG_W - 1;    // Local sequence bits
    localparam int NUM_SEQ    = 2 ** SEQ_W;       // Distinct local tags

    // --------------------
    // Channel types
    // --------------------

    // Line address in host memory
    typedef logic [LINE_ADDR_W-1:0] lineAddr_t;

    // Request tag, client bit on top
    typedef logic [REQ_TAG_W-1:0] reqTag_t;

    // Local part of a tag
    typedef logic [SEQ_W-1:0] seqNum_t;

    // Payload of one read response
    typedef logic [LINE_DATA_W-1:0] lineData_t;

    // --------------------
    // Fetcher types
    // --------------------

    // Wrapping sum of returned lines
    typedef logic [LINE_DATA_W-1:0] lineSum_t;

    // Number of lines in one fetch
    typedef logic [LINE_COUNT_W-1:0] lineCount_t;

    // Fetcher FSM
    //   IDLE   waits for start
    //   ISSUE  sends one request per cycle when not blocked
    //   DRAIN  all issued, waits for the remaining responses
    //   DONE   one cycle, drives the done pulse
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } fetchState_t;

endpackage

/* hdl/hostChannelShim.sv */
// Edge shim between the host read channel wires and the internal c0 channel
// Each direction is either registered or passed straight through
`timescale 1ns/1ps

module hostChannelShim
    import hostIfPkg::*;
#(
    parameter int REGISTER_INPUTS  = 1,   // Register responses and almFull
    parameter int REGISTER_OUTPUTS = 1    // Register requests
)
(
    input  logic      clk,
    input  logic      rst,

    // Internal side
    input  logic      c0ReqValid,
    input  lineAddr_t c0ReqAddr,
    input  reqTag_t   c0ReqTag,
    output logic      c0AlmFull,
    output logic      c0RspValid,
    output reqTag_t   c0RspTag,
    output lineData_t c0RspData,

    // Host side
    output logic      hostReqValid,
    output lineAddr_t hostReqAddr,
    output reqTag_t   hostReqTag,
    input  logic      hostAlmFull,
    input  logic      hostRspValid,
    input  reqTag_t   hostRspTag,
    input  lineData_t hostRspData
);

    // --------------------
    // Request path
    // --------------------
    generate
        if (REGISTER_OUTPUTS != 0)
        begin : regOut
            always_ff @(posedge clk)
            begin
                if (rst)
                    hostReqValid <= 1'b0;           // Nothing leaves after reset
                else
                    hostReqValid <= c0ReqValid;
                hostReqAddr <= c0ReqAddr;
                hostReqTag  <= c0ReqTag;
            end
        end
        else
        begin : wireOut
            assign hostReqValid = c0ReqValid;
            assign hostReqAddr  = c0ReqAddr;
            assign hostReqTag   = c0ReqTag;
        end
    endgenerate

    // --------------------
    // Response path
    // --------------------
    // almFull travels with the responses, one stage when registered
    generate
        if (REGISTER_INPUTS != 0)
        begin : regIn
            always_ff @(posedge clk)
            begin
                if (rst)
                begin
                    c0RspValid <= 1'b0;
                    c0AlmFull  <= 1'b0;
                end
                else
                begin
                    c0RspValid <= hostRspValid;
                    c0AlmFull  <= hostAlmFull;
                end
                c0RspTag  <= hostRspTag;
                c0RspData <= hostRspData;
            end
        end
        else
        begin : wireIn
            assign c0RspValid = hostRspValid;
            assign c0AlmFull  = hostAlmFull;
            assign c0RspTag   = hostRspTag;
            assign c0RspData  = hostRspData;
        end
    endgenerate

endmodule

/* hdl/readArbiter.sv */
// Round-robin arbiter sharing one c0 read channel between two fetchers
// Marks the client in the top tag bit and steers responses back by that bit
`timescale 1ns/1ps

module readArbiter
    import hostIfPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Client 0
    input  logic      reqValid0,
    input  lineAddr_t reqAddr0,
    input  reqTag_t   reqTag0,
    output logic      almFull0,
    output logic      rspValid0,
    output reqTag_t   rspTag0,
    output lineData_t rspData0,

    // Client 1
    input  logic      reqValid1,
    input  lineAddr_t reqAddr1,
    input  reqTag_t   reqTag1,
    output logic      almFull1,
    output logic      rspValid1,
    output reqTag_t   rspTag1,
    output lineData_t rspData1,

    // Toward the shim
    output logic      c0ReqValid,
    output lineAddr_t c0ReqAddr,
    output reqTag_t   c0ReqTag,
    input  logic      c0AlmFull,
    input  logic      c0RspValid,
    input  reqTag_t   c0RspTag,
    input  lineData_t c0RspData
);

    logic rrPtr;          // Client that wins a tie
    logic grant0;
    logic grant1;
    seqNum_t grantSeq;    // Local tag bits of the winner

    // --------------------
    // Grant
    // --------------------
    // No grant at all while the host is almost full
    always_comb
    begin
        grant0 = 1'b0;
        grant1 = 1'b0;
        if (!c0AlmFull)
        begin
            if (reqValid0 && reqValid1)
            begin
                grant0 = !rrPtr;
                grant1 = rrPtr;
            end
            else
            begin
                grant0 = reqValid0;
                grant1 = reqValid1;
            end
        end
    end

    // A waiting loser sees almFull and keeps its request
    assign almFull0 = c0AlmFull | (reqValid0 & ~grant0);
    assign almFull1 = c0AlmFull | (reqValid1 & ~grant1);

    assign grantSeq = grant1 ? reqTag1[SEQ_W-1:0] : reqTag0[SEQ_W-1:0];

    // Pointer moves to the other client after every grant
    always_ff @(posedge clk)
    begin
        if (rst)
            rrPtr <= 1'b0;
        else if (grant0)
            rrPtr <= 1'b1;
        else if (grant1)
            rrPtr <= 1'b0;
    end

    // --------------------
    // Request register
    // --------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            c0ReqValid <= 1'b0;
        else
            c0ReqValid <= grant0 | grant1;
        c0ReqAddr <= grant1 ? reqAddr1 : reqAddr0;
        c0ReqTag  <= {grant1, grantSeq};      // Client number on top
    end

    // --------------------
    // Response steering
    // --------------------
    assign rspValid0 = c0RspValid & ~c0RspTag[CLIENT_BIT];
    assign rspValid1 = c0RspValid & c0RspTag[CLIENT_BIT];

    // Client bit stripped, local bits unchanged
    assign rspTag0 = {1'b0, c0RspTag[SEQ_W-1:0]};
    assign rspTag1 = {1'b0, c0RspTag[SEQ_W-1:0]};

    assign rspData0 = c0RspData;              // Shared data bus
    assign rspData1 = c0RspData;

endmodule

/* hdl/lineFetcher.sv */
// Reads a run of lines from host memory and sums them with wraparound
// Pulse start with base and count, wait for done, then read sum
`timescale 1ns/1ps

module lineFetcher
    import hostIfPkg::*;
#(
    parameter int MAX_OUTSTANDING = 16    // Reads in flight, up to 64
)
(
    input  logic       clk,
    input  logic       rst,

    // Control
    input  logic       start,
    input  lineAddr_t  base,
    input  lineCount_t count,
    output logic       busy,
    output logic       done,
    output lineSum_t   sum,

    // Read channel
    output logic       reqValid,
    output lineAddr_t  reqAddr,
    output reqTag_t    reqTag,
    input  logic       almFull,
    input  logic       rspValid,
    input  reqTag_t    rspTag,
    input  lineData_t  rspData
);

    localparam int PEND_W = $clog2(MAX_OUTSTANDING + 1);

    fetchState_t state;
    lineAddr_t   curAddr;                 // Next address to request
    lineCount_t  issueLeft;               // Requests still to send
    lineCount_t  rspLeft;                 // Responses still to come
    seqNum_t     seqCnt;                  // Local tag of next request
    seqNum_t     rspSeq;
    logic [PEND_W-1:0]  pendingCnt;       // Reads in flight
    logic [NUM_SEQ-1:0] inFlight;         // One bit per local tag
    logic startTake;
    logic canIssue;
    logic issueFire;
    logic rspTake;

    // --------------------
    // Issue control
    // --------------------
    assign startTake = start && ((state == IDLE) || (state == DONE));

    // Held off by the pending limit or a tag still in use
    assign canIssue = (state == ISSUE) && (issueLeft != '0)
                      && (pendingCnt < PEND_W'(MAX_OUTSTANDING))
                      && !inFlight[seqCnt];
    assign issueFire = canIssue && !almFull;          // Request taken this cycle
    assign rspTake   = rspValid && ((state == ISSUE) || (state == DRAIN));
    assign rspSeq    = rspTag[SEQ_W-1:0];

    assign reqValid = canIssue;
    assign reqAddr  = curAddr;
    assign reqTag   = {1'b0, seqCnt};                 // Arbiter fills top bit

    assign busy = (state == ISSUE) || (state == DRAIN);
    assign done = (state == DONE);

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE, DONE:
                begin
                    if (startTake)
                        state <= (count == '0) ? DONE : ISSUE;  // Empty run ends at once
                    else
                        state <= IDLE;
                end
                ISSUE:
                begin
                    if (issueFire && (issueLeft == lineCount_t'(1)))
                        state <= DRAIN;                         // Last request sent
                end
                DRAIN:
                begin
                    if (rspTake && (rspLeft == lineCount_t'(1)))
                        state <= DONE;                          // Last response in
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // --------------------
    // Address, counters, sum
    // --------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            issueLeft <= '0;
            rspLeft   <= '0;
            seqCnt    <= '0;
            sum       <= '0;
        end
        else if (startTake)
        begin
            issueLeft <= count;
            rspLeft   <= count;
            sum       <= '0;                  // Fresh sum per run
        end
        else
        begin
            if (issueFire)
            begin
                issueLeft <= issueLeft - 1'b1;
                seqCnt    <= seqCnt + 1'b1;
            end
            if (rspTake)
            begin
                rspLeft <= rspLeft - 1'b1;
                sum     <= sum + rspData;     // Wraps at 64 bits
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (startTake)
            curAddr <= base;
        else if (issueFire)
            curAddr <= curAddr + 1'b1;        // Sequential lines
    end

    // Pending count and tag map
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pendingCnt <= '0;
            inFlight   <= '0;
        end
        else
        begin
            if (issueFire && !rspTake)
                pendingCnt <= pendingCnt + 1'b1;
            else if (rspTake && !issueFire)
                pendingCnt <= pendingCnt - 1'b1;
            if (rspTake)
                inFlight[rspSeq] <= 1'b0;     // Tag free again
            if (issueFire)
                inFlight[seqCnt] <= 1'b1;
        end
    end

endmodule

/* hdl/fetchSubsystem.sv */
// Top level of the host read subsystem
// Two line fetchers share the host channel through the arbiter and edge shim
`timescale 1ns/1ps

module fetchSubsystem
    import hostIfPkg::*;
#(
    parameter int REGISTER_INPUTS  = 1,
    parameter int REGISTER_OUTPUTS = 1,
    parameter int MAX_OUTSTANDING  = 16
)
(
    input  logic       clk,
    input  logic       rst,

    // Fetcher 0 control
    input  logic       start0,
    input  lineAddr_t  base0,
    input  lineCount_t count0,
    output logic       busy0,
    output logic       done0,
    output lineSum_t   sum0,

    // Fetcher 1 control
    input  logic       start1,
    input  lineAddr_t  base1,
    input  lineCount_t count1,
    output logic       busy1,
    output logic       done1,
    output lineSum_t   sum1,

    // Host channel
    output logic       hostReqValid,
    output lineAddr_t  hostReqAddr,
    output reqTag_t    hostReqTag,
    input  logic       hostAlmFull,
    input  logic       hostRspValid,
    input  reqTag_t    hostRspTag,
    input  lineData_t  hostRspData
);

    // --------------------
    // Fetcher to arbiter
    // --------------------
    logic      reqValid0;
    lineAddr_t reqAddr0;
    reqTag_t   reqTag0;
    logic      almFull0;
    logic      rspValid0;
    reqTag_t   rspTag0;
    lineData_t rspData0;

    logic      reqValid1;
    lineAddr_t reqAddr1;
    reqTag_t   reqTag1;
    logic      almFull1;
    logic      rspValid1;
    reqTag_t   rspTag1;
    lineData_t rspData1;

    // Arbiter to shim
    logic      c0ReqValid;
    lineAddr_t c0ReqAddr;
    reqTag_t   c0ReqTag;
    logic      c0AlmFull;
    logic      c0RspValid;
    reqTag_t   c0RspTag;
    lineData_t c0RspData;

    lineFetcher #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) fetch0 (
        .clk(clk), .rst(rst),
        .start(start0), .base(base0), .count(count0),
        .busy(busy0), .done(done0), .sum(sum0),
        .reqValid(reqValid0), .reqAddr(reqAddr0), .reqTag(reqTag0),
        .almFull(almFull0), .rspValid(rspValid0), .rspTag(rspTag0), .rspData(rspData0)
    );

    lineFetcher #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) fetch1 (
        .clk(clk), .rst(rst),
        .start(start1), .base(base1), .count(count1),
        .busy(busy1), .done(done1), .sum(sum1),
        .reqValid(reqValid1), .reqAddr(reqAddr1), .reqTag(reqTag1),
        .almFull(almFull1), .rspValid(rspValid1), .rspTag(rspTag1), .rspData(rspData1)
    );

    readArbiter arb0 (
        .clk(clk), .rst(rst),
        .reqValid0(reqValid0), .reqAddr0(reqAddr0), .reqTag0(reqTag0),
        .almFull0(almFull0), .rspValid0(rspValid0), .rspTag0(rspTag0), .rspData0(rspData0),
        .reqValid1(reqValid1), .reqAddr1(reqAddr1), .reqTag1(reqTag1),
        .almFull1(almFull1), .rspValid1(rspValid1), .rspTag1(rspTag1), .rspData1(rspData1),
        .c0ReqValid(c0ReqValid), .c0ReqAddr(c0ReqAddr), .c0ReqTag(c0ReqTag),
        .c0AlmFull(c0AlmFull), .c0RspValid(c0RspValid), .c0RspTag(c0RspTag),
        .c0RspData(c0RspData)
    );

    // Host edge
    hostChannelShim #(
        .REGISTER_INPUTS(REGISTER_INPUTS),
        .REGISTER_OUTPUTS(REGISTER_OUTPUTS)
    ) shim0 (
        .clk(clk), .rst(rst),
        .c0ReqValid(c0ReqValid), .c0ReqAddr(c0ReqAddr), .c0ReqTag(c0ReqTag),
        .c0AlmFull(c0AlmFull), .c0RspValid(c0RspValid), .c0RspTag(c0RspTag),
        .c0RspData(c0RspData),
        .hostReqValid(hostReqValid), .hostReqAddr(hostReqAddr), .hostReqTag(hostReqTag),
        .hostAlmFull(hostAlmFull), .hostRspValid(hostRspValid), .hostRspTag(hostRspTag),
        .hostRspData(hostRspData)
    );

endmodule

/* testbench/clockGen.sv */
// Clock and reset source for the fetch subsystem testbench
// 10 ns clock, synchronous reset held high for the first 2 rising edges
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                        // Released on an edge like other inputs
    end

endmodule

/* testbench/hostMemModel.sv */
// Host memory responder for the c0 read channel, with random latency and almost-full
// Checks tag use, per-client address repeats, pending limits and almost-full slack
// Prints the reason of a violation and raises protocolError for the testbench top
`timescale 1ns/1ps

module hostMemModel
    import hostIfPkg::*;
#(
    parameter int MAX_OUTSTANDING = 16
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hostReqValid,
    input  lineAddr_t hostReqAddr,
    input  reqTag_t   hostReqTag,
    output logic      hostAlmFull,
    output logic      hostRspValid,
    output reqTag_t   hostRspTag,
    output lineData_t hostRspData,
    input  logic      afEnable,         // Random almost-full on
    input  logic      slowRsp,          // Every response at the maximum delay
    input  logic      clearLog,         // New run, forget seen addresses
    output int        issued0,
    output int        issued1,
    output logic      protocolError
);

    localparam int ALM_FULL_SLACK = 4;  // Requests tolerated after almFull rises
    localparam int TABLE_SIZE     = 64;
    localparam int MAX_DELAY      = 8;

    int        seed = 83;
    logic      pendValid [TABLE_SIZE];
    lineAddr_t pendAddr  [TABLE_SIZE];
    reqTag_t   pendTag   [TABLE_SIZE];
    int        pendWait  [TABLE_SIZE];  // Cycles until release
    int        seen0 [lineAddr_t];      // Addresses per client in this run
    int        seen1 [lineAddr_t];
    int        lateReqs;                // Requests since almFull went high

    // Quiet channel from time zero
    initial
    begin
        hostAlmFull  = 1'b0;
        hostRspValid = 1'b0;
        hostRspTag   = '0;
        hostRspData  = '0;
    end

    always @(posedge clk)
    begin : hostSide
        int   freeSlot;
        int   pend0;
        int   pend1;
        logic sent;
        logic tagBusy;
        if (rst)
        begin
            for (int i = 0; i < TABLE_SIZE; i++)
                pendValid[i] = 1'b0;
            lateReqs = 0;
            hostAlmFull   <= 1'b0;
            hostRspValid  <= 1'b0;
            protocolError <= 1'b0;
            issued0 <= 0;
            issued1 <= 0;
        end
        else
        begin
            // --------------------
            // Responses, one per cycle
            // --------------------
            hostRspValid <= 1'b0;
            sent = 1'b0;
            for (int i = 0; i < TABLE_SIZE; i++)
            begin
                if (pendValid[i] && (pendWait[i] > 0))
                    pendWait[i] = pendWait[i] - 1;
            end
            for (int i = 0; i < TABLE_SIZE; i++)
            begin
                if (pendValid[i] && (pendWait[i] == 0) && !sent)
                begin
                    hostRspValid <= 1'b1;
                    hostRspTag   <= pendTag[i];
                    hostRspData  <= {pendAddr[i], ~pendAddr[i]};  // Address over inverse
                    pendValid[i] = 1'b0;
                    sent = 1'b1;
                end
            end

            if (clearLog)
            begin
                seen0.delete();
                seen1.delete();
                issued0 <= 0;
                issued1 <= 0;
            end

            // --------------------
            // Requests
            // --------------------
            if (hostReqValid)
            begin
                freeSlot = -1;
                tagBusy  = 1'b0;
                for (int i = 0; i < TABLE_SIZE; i++)
                begin
                    if (pendValid[i] && (pendTag[i] == hostReqTag))
                        tagBusy = 1'b1;
                    if (!pendValid[i] && (freeSlot < 0))
                        freeSlot = i;
                end
                assert (!tagBusy)
                else
                begin
                    $display("Host model at %0t: tag %h reused while outstanding",
                             $time, hostReqTag);
                    protocolError <= 1'b1;
                end
                if (hostReqTag[CLIENT_BIT])
                begin
                    assert (!seen1.exists(hostReqAddr))
                    else
                    begin
                        $display("Host model at %0t: client 1 read %h twice",
                                 $time, hostReqAddr);
                        protocolError <= 1'b1;
                    end
                    seen1[hostReqAddr] = 1;
                    issued1 <= issued1 + 1;
                end
                else
                begin
                    assert (!seen0.exists(hostReqAddr))
                    else
                    begin
                        $display("Host model at %0t: client 0 read %h twice",
                                 $time, hostReqAddr);
                        protocolError <= 1'b1;
                    end
                    seen0[hostReqAddr] = 1;
                    issued0 <= issued0 + 1;
                end
                assert (freeSlot >= 0)
                else
                begin
                    $display("Host model at %0t: pending table overflow", $time);
                    protocolError <= 1'b1;
                end
                if (freeSlot >= 0)
                begin
                    pendValid[freeSlot] = 1'b1;
                    pendAddr[freeSlot]  = hostReqAddr;
                    pendTag[freeSlot]   = hostReqTag;
                    pendWait[freeSlot]  = slowRsp ? MAX_DELAY : 1 + ($random(seed) & 7);
                end
            end

            // Pending per client, client from the top tag bit
            pend0 = 0;
            pend1 = 0;
            for (int i = 0; i < TABLE_SIZE; i++)
            begin
                if (pendValid[i] && pendTag[i][CLIENT_BIT])
                    pend1 = pend1 + 1;
                else if (pendValid[i])
                    pend0 = pend0 + 1;
            end
            assert ((pend0 <= MAX_OUTSTANDING) && (pend1 <= MAX_OUTSTANDING))
            else
            begin
                $display("Host model at %0t: pending reads %0d/%0d above limit %0d",
                         $time, pend0, pend1, MAX_OUTSTANDING);
                protocolError <= 1'b1;
            end

            // --------------------
            // Almost-full
            // --------------------
            if (!hostAlmFull)
                lateReqs = 0;
            else if (hostReqValid)
                lateReqs = lateReqs + 1;
            assert (lateReqs <= ALM_FULL_SLACK)
            else
            begin
                $display("Host model at %0t: %0d requests arrived after almost-full",
                         $time, lateReqs);
                protocolError <= 1'b1;
            end
            if (!afEnable)
                hostAlmFull <= 1'b0;
            else if (($random(seed) & 15) == 0)
                hostAlmFull <= !hostAlmFull;        // Long random stretches
        end
    end

endmodule

/* testbench/fetchTb.sv */
// Testbench top for the fetch subsystem
// Runs single, concurrent, back-pressured, empty and latency-bound fetches
`timescale 1ns/1ps

module fetchTb
    import hostIfPkg::*;
();

    localparam int MAX_OUT         = 4;     // Low enough that the limit is reached
    localparam int TOTAL_LINES     = 40 + 48 + 48 + 64 + 64 + 60 + 60;
    localparam int WATCHDOG_CYCLES = TOTAL_LINES * 20 + 1000;

    logic       clk;
    logic       rst;
    logic       start0;
    lineAddr_t  base0;
    lineCount_t count0;
    logic       start1;
    lineAddr_t  base1;
    lineCount_t count1;
    logic       busy0;
    logic       done0;
    lineSum_t   sum0;
    logic       busy1;
    logic       done1;
    lineSum_t   sum1;
    logic       hostReqValid;
    lineAddr_t  hostReqAddr;
    reqTag_t    hostReqTag;
    logic       hostAlmFull;
    logic       hostRspValid;
    reqTag_t    hostRspTag;
    lineData_t  hostRspData;
    logic       afEnable;
    logic       slowRsp;
    logic       clearLog;
    int         issued0;
    int         issued1;
    logic       protocolError;
    int         doneCnt0 = 0;
    int         doneCnt1 = 0;

    clockGen clk0 (.clk(clk), .rst(rst));

    fetchSubsystem #(
        .REGISTER_INPUTS(1),
        .REGISTER_OUTPUTS(1),
        .MAX_OUTSTANDING(MAX_OUT)
    ) dut0 (
        .clk(clk), .rst(rst),
        .start0(start0), .base0(base0), .count0(count0),
        .busy0(busy0), .done0(done0), .sum0(sum0),
        .start1(start1), .base1(base1), .count1(count1),
        .busy1(busy1), .done1(done1), .sum1(sum1),
        .hostReqValid(hostReqValid), .hostReqAddr(hostReqAddr), .hostReqTag(hostReqTag),
        .hostAlmFull(hostAlmFull), .hostRspValid(hostRspValid), .hostRspTag(hostRspTag),
        .hostRspData(hostRspData)
    );

    hostMemModel #(
        .MAX_OUTSTANDING(MAX_OUT)
    ) mem0 (
        .clk(clk), .rst(rst),
        .hostReqValid(hostReqValid), .hostReqAddr(hostReqAddr), .hostReqTag(hostReqTag),
        .hostAlmFull(hostAlmFull), .hostRspValid(hostRspValid), .hostRspTag(hostRspTag),
        .hostRspData(hostRspData),
        .afEnable(afEnable), .slowRsp(slowRsp), .clearLog(clearLog),
        .issued0(issued0), .issued1(issued1), .protocolError(protocolError)
    );

    // --------------------
    // Reference and checks
    // --------------------
    // Host word is the address on top of its inverse
    function automatic lineSum_t expectedSum(input lineAddr_t base, input lineCount_t count);
        lineSum_t  acc;
        lineAddr_t addr;
        acc = '0;
        for (int i = 0; i < int'(count); i++)
        begin
            addr = base + lineAddr_t'(i);
            acc  = acc + {addr, ~addr};             // Wraps at 64 bits
        end
        return acc;
    endfunction

    task automatic failRun();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH time %0t: %s = %h, expected %h", $time, name, got, exp);
            failRun();
        end
    endtask

    // Starts either fetcher, waits for its done pulses, then checks the results
    task automatic runFetch(input logic go0, input lineAddr_t b0, input lineCount_t c0,
                            input logic go1, input lineAddr_t b1, input lineCount_t c1);
        int want0;
        int want1;
        want0 = doneCnt0 + (go0 ? 1 : 0);
        want1 = doneCnt1 + (go1 ? 1 : 0);
        @(posedge clk);
        clearLog <= 1'b1;
        @(posedge clk);
        clearLog <= 1'b0;
        start0 <= go0;
        base0  <= b0;
        count0 <= c0;
        start1 <= go1;
        base1  <= b1;
        count1 <= c1;
        @(posedge clk);
        start0 <= 1'b0;
        start1 <= 1'b0;
        while ((doneCnt0 < want0) || (doneCnt1 < want1))
            @(negedge clk);
        repeat (4) @(negedge clk);                  // Room for a stray second pulse
        checkValue("done0 pulses", doneCnt0, want0);
        checkValue("done1 pulses", doneCnt1, want1);
        checkValue("busy0", busy0, 0);
        checkValue("busy1", busy1, 0);
        if (go0)
        begin
            checkValue("sum0", sum0, expectedSum(b0, c0));
            checkValue("client 0 requests", issued0, c0);
        end
        if (go1)
        begin
            checkValue("sum1", sum1, expectedSum(b1, c1));
            checkValue("client 1 requests", issued1, c1);
        end
    endtask

    // Pulses counted on the edge that ends them
    always @(posedge clk)
    begin
        if (done0)
            doneCnt0 = doneCnt0 + 1;
        if (done1)
            doneCnt1 = doneCnt1 + 1;
    end

    // Host model violations end the run here
    initial
    begin
        wait (protocolError === 1'b1);
        $display("Host model reported a protocol violation at %0t", $time);
        failRun();
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, a fetch never finished", WATCHDOG_CYCLES);
        failRun();
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        start0   = 1'b0;
        base0    = '0;
        count0   = '0;
        start1   = 1'b0;
        base1    = '0;
        count1   = '0;
        afEnable = 1'b0;
        slowRsp  = 1'b0;
        clearLog = 1'b0;

        @(negedge clk);
        while (rst !== 1'b0)
            @(negedge clk);
        repeat (4)                                  // Quiet until the first start
        begin
            checkValue("hostReqValid", hostReqValid, 0);
            checkValue("busy0", busy0, 0);
            checkValue("busy1", busy1, 0);
            checkValue("done0", done0, 0);
            checkValue("done1", done1, 0);
            checkValue("sum0", sum0, 0);
            checkValue("sum1", sum1, 0);
            @(negedge clk);
        end

        runFetch(1'b1, 32'h100, 16'd40, 1'b0, '0, '0);
        runFetch(1'b1, 32'h200, 16'd48, 1'b1, 32'h220, 16'd48);   // Overlapping

        @(posedge clk);
        afEnable <= 1'b1;
        runFetch(1'b1, 32'h1000, 16'd64, 1'b1, 32'h1010, 16'd64);
        @(posedge clk);
        afEnable <= 1'b0;

        runFetch(1'b1, 32'h300, 16'd0, 1'b1, 32'h380, 16'd0);     // Empty runs

        // Each client alone, so it can issue every cycle
        @(posedge clk);
        slowRsp <= 1'b1;
        runFetch(1'b1, 32'h4000, 16'd60, 1'b0, '0, '0);
        runFetch(1'b0, '0, '0, 1'b1, 32'h5000, 16'd60);
        @(posedge clk);
        slowRsp <= 1'b0;

        repeat (2) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

/* src.f */
hdl/hostIfPkg.sv
hdl/hostChannelShim.sv
hdl/readArbiter.sv
hdl/lineFetcher.sv
hdl/fetchSubsystem.sv
testbench/clockGen.sv
testbench/hostMemModel.sv
testbench/fetchTb.sv

/* Makefile */
# Verilator build and run for the fetch subsystem testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = fetchTb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = run.log
PASS_MSG = Verification passed

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || { echo "FAIL"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
